/* error_subsystem.f */
+incdir+rtl
rtl/error_pkg.sv
rtl/error_capture.sv
rtl/error_control.sv
rtl/error_report_mmio.sv
rtl/error_subsystem.sv
verification/error_checker.sv
verification/error_subsystem_tb.sv

/* verification/error_subsystem_tb.sv */
`timescale 1ns/1ps

module error_subsystem_tb;

	import error_pkg::*;

	// Read rounds over all tests, 200 cycles each
	localparam int ROUNDS          = 12;
	localparam int WATCHDOG_CYCLES = ROUNDS * 200 + 50;

	logic        clock;
	logic        rstn;
	logic        enabled;
	cmd_error_t  cmd_errors;
	rsp_error_t  rsp_errors;
	data_error_t data_errors;
	logic        host_req_valid;
	logic        host_req_ready;
	host_req_t   host_req;
	logic        host_rsp_valid;
	logic        host_rsp_ready;
	host_rsp_t   host_rsp;
	logic        error_interrupt;

	// Checker control
	logic [3:0] test_num;
	logic       test_end;
	logic       run_done;
	int         checker_errors;
	int         tb_errors;

	int          seed;
	logic [15:0] r_cmd;
	logic [15:0] r_rsp;
	logic [31:0] r_data;
	logic [31:0] a_data;
	logic        ok;
	int          rounds;

	error_subsystem i_error_subsystem (
		.clock           (clock),
		.rstn            (rstn),
		.enabled         (enabled),
		.cmd_errors      (cmd_errors),
		.rsp_errors      (rsp_errors),
		.data_errors     (data_errors),
		.host_req_valid  (host_req_valid),
		.host_req_ready  (host_req_ready),
		.host_req        (host_req),
		.host_rsp_valid  (host_rsp_valid),
		.host_rsp_ready  (host_rsp_ready),
		.host_rsp        (host_rsp),
		.error_interrupt (error_interrupt)
	);

	error_checker i_error_checker (
		.clock           (clock),
		.rstn            (rstn),
		.cmd_errors      (cmd_errors),
		.rsp_errors      (rsp_errors),
		.data_errors     (data_errors),
		.host_req_valid  (host_req_valid),
		.host_req_ready  (host_req_ready),
		.host_req        (host_req),
		.host_rsp_valid  (host_rsp_valid),
		.host_rsp_ready  (host_rsp_ready),
		.host_rsp        (host_rsp),
		.error_interrupt (error_interrupt),
		.test_num        (test_num),
		.test_end        (test_end),
		.run_done        (run_done),
		.stim_errors     (tb_errors),
		.error_count     (checker_errors)
	);

	// --------------------
	// Clock and watchdog
	// --------------------

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin
		#(WATCHDOG_CYCLES * 20);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	// --------------------
	// Stimulus tasks
	// --------------------

	task automatic randomize_errors();
		r_cmd  = $random(seed);
		r_rsp  = $random(seed);
		r_data = $random(seed);
	endtask

	// One-cycle flags on all three sources
	task automatic pulse_errors(input logic [15:0] c, input logic [15:0] r,
			input logic [31:0] d);
		cmd_errors  <= c;
		rsp_errors  <= r;
		data_errors <= d;
		@(posedge clock);
		cmd_errors  <= '0;
		rsp_errors  <= '0;
		data_errors <= '0;
	endtask

	task automatic wait_interrupt(input logic level, input int max_cycles,
			input bit report, output logic seen);
		int cnt;
		cnt = 0;
		while (error_interrupt !== level && cnt < max_cycles) begin
			@(posedge clock);
			cnt++;
		end
		seen = (error_interrupt === level);
		if (!seen && report) begin
			$display("interrupt did not go to %b within %0d cycles at %0t", level,
				max_cycles, $time);
			tb_errors++;
		end
	endtask

	task automatic check_quiet(input int cycles);
		repeat (cycles) begin
			@(posedge clock);
			if (error_interrupt) begin
				$display("interrupt raised with no report expected at %0t", $time);
				tb_errors++;
			end
		end
	endtask

	// Read with an optional stall on the response side
	task automatic host_read(input int stall);
		int cnt;
		host_rsp_ready <= (stall == 0);
		host_req_valid <= 1'b1;
		host_req.tag   <= $random(seed);
		cnt = 0;
		do begin
			@(posedge clock);
			cnt++;
		end while (!host_req_ready && cnt < 20);
		host_req_valid <= 1'b0;
		if (stall > 0) begin
			repeat (stall) @(posedge clock);
			host_rsp_ready <= 1'b1;
		end
		cnt = 0;
		do begin
			@(posedge clock);
			cnt++;
		end while (!(host_rsp_valid && host_rsp_ready) && cnt < 20);
		if (!(host_rsp_valid && host_rsp_ready)) begin
			$display("host read got no response at %0t", $time);
			tb_errors++;
		end
		host_rsp_ready <= 1'b1;
	endtask

	task automatic end_test(input int n);
		test_num <= n;
		test_end <= 1'b1;
		@(posedge clock);
		test_end <= 1'b0;
	endtask

	// --------------------
	// Test sequence
	// --------------------

	initial begin
		seed           = 32'h53db_ee78;
		rstn           = 1'b0;
		enabled        = 1'b1;
		cmd_errors     = '0;
		rsp_errors     = '0;
		data_errors    = '0;
		host_req_valid = 1'b0;
		host_req       = '0;
		host_rsp_ready = 1'b1;
		test_num       = '0;
		test_end       = 1'b0;
		run_done       = 1'b0;
		tb_errors      = 0;
		repeat (10) @(posedge clock);
		rstn <= 1'b1;
		repeat (6) @(posedge clock);

		// Command source alone
		randomize_errors();
		pulse_errors(r_cmd | 16'h1, '0, '0);
		wait_interrupt(1'b1, 5, 1'b1, ok);
		host_read(0);
		wait_interrupt(1'b0, 4, 1'b1, ok);
		end_test(1);

		// Back to back pulses, later ones may spill into further rounds
		repeat (3) begin
			randomize_errors();
			pulse_errors(r_cmd, r_rsp, r_data | 32'h1);
		end
		rounds = 0;
		wait_interrupt(1'b1, 5, 1'b1, ok);
		while (ok && rounds < 3) begin
			host_read(0);
			wait_interrupt(1'b0, 4, 1'b1, ok);
			rounds++;
			wait_interrupt(1'b1, 8, 1'b0, ok);
		end
		end_test(2);

		// Second batch disjoint from the first, so it survives the clear
		randomize_errors();
		a_data = r_data & ~32'h1;
		pulse_errors(r_cmd, r_rsp, a_data);
		wait_interrupt(1'b1, 5, 1'b1, ok);
		randomize_errors();
		pulse_errors('0, '0, (r_data & ~a_data) | 32'h1);
		pulse_errors('0, '0, 32'h1);
		host_read(0);
		wait_interrupt(1'b0, 4, 1'b1, ok);
		wait_interrupt(1'b1, 5, 1'b1, ok);
		host_read(0);
		wait_interrupt(1'b0, 4, 1'b1, ok);
		end_test(3);

		check_quiet(5);
		host_read(0);
		check_quiet(8);
		end_test(4);

		// Control frozen, captures keep collecting
		enabled <= 1'b0;
		repeat (3) @(posedge clock);
		repeat (3) begin
			randomize_errors();
			pulse_errors(r_cmd, r_rsp, r_data | 32'h1);
		end
		check_quiet(10);
		enabled <= 1'b1;
		wait_interrupt(1'b1, 5, 1'b1, ok);
		host_read(0);
		wait_interrupt(1'b0, 4, 1'b1, ok);
		end_test(5);

		repeat (3) begin
			randomize_errors();
			pulse_errors(r_cmd, r_rsp, r_data | 32'h1);
			wait_interrupt(1'b1, 5, 1'b1, ok);
			host_read($unsigned($random(seed)) % 6 + 1);
			wait_interrupt(1'b0, 4, 1'b1, ok);
		end
		host_read($unsigned($random(seed)) % 6 + 1);
		end_test(6);

		run_done <= 1'b1;
		@(posedge clock);
		run_done <= 1'b0;
		@(posedge clock);
		if (checker_errors == 0 && tb_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* verification/error_checker.sv */
`timescale 1ns/1ps

`include "error_consts.svh"

module error_checker (
	input  logic                   clock,
	input  logic                   rstn,
	input  error_pkg::cmd_error_t  cmd_errors,
	input  error_pkg::rsp_error_t  rsp_errors,
	input  error_pkg::data_error_t data_errors,
	input  logic                   host_req_valid,
	input  logic                   host_req_ready,
	input  error_pkg::host_req_t   host_req,
	input  logic                   host_rsp_valid,
	input  logic                   host_rsp_ready,
	input  error_pkg::host_rsp_t   host_rsp,
	input  logic                   error_interrupt,
	input  logic [3:0]             test_num,
	input  logic                   test_end,
	input  logic                   run_done,
	input  int                     stim_errors,
	output int                     error_count
);

	import error_pkg::*;

	localparam int CMD_W  = `ERR_CMD_WIDTH;
	localparam int RSP_W  = `ERR_RSP_WIDTH;
	localparam int DATA_W = `ERR_DATA_WIDTH;
	localparam int WORD_W = CMD_W + RSP_W + DATA_W;

	// Flags seen since the last clear, per source
	logic [CMD_W-1:0]  acc_cmd;
	logic [RSP_W-1:0]  acc_rsp;
	logic [DATA_W-1:0] acc_data;

	// Packed history, one to three edges back at the start of an edge
	logic [WORD_W-1:0] acc_now;
	logic [WORD_W-1:0] acc_d1;
	logic [WORD_W-1:0] acc_d2;
	logic [WORD_W-1:0] snap;

	logic      int_prev;
	logic      exp_pending;
	logic [3:0] exp_tag;
	logic      prev_stalled;
	logic      clear_due;
	logic      rsp_due;
	host_rsp_t prev_rsp;
	host_rsp_t expected;
	int        check_count;
	int        test_base;

	// --------------------
	// Reference model
	// --------------------

	// Command field on top, then response, data at the bottom
	function automatic logic [WORD_W-1:0] pack_word(input logic [CMD_W-1:0] c,
			input logic [RSP_W-1:0] r, input logic [DATA_W-1:0] d);
		return {c, r, d};
	endfunction

	// Snapshot when a report was pending, zero otherwise
	function automatic host_rsp_t expected_response(input logic [3:0] tag,
			input logic pending, input logic [WORD_W-1:0] snapshot);
		host_rsp_t r;
		r.tag     = tag;
		r.pending = pending;
		r.data    = pending ? snapshot : '0;
		return r;
	endfunction

	task automatic report_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		error_count++;
	endtask

	function automatic string test_name(input int n);
		case (n)
			1: return "single source";
			2: return "accumulation";
			3: return "errors during report";
			4: return "idle read";
			5: return "enable gating";
			6: return "response back-pressure";
			default: return "unknown";
		endcase
	endfunction

	// --------------------
	// Compare process
	// --------------------

	always @(posedge clock) begin
		if (!rstn) begin
			acc_cmd      = '0;
			acc_rsp      = '0;
			acc_data     = '0;
			acc_now      = '0;
			acc_d1       = '0;
			acc_d2       = '0;
			snap         = '0;
			int_prev     = 1'b0;
			exp_pending  = 1'b0;
			exp_tag      = '0;
			prev_stalled = 1'b0;
			clear_due    = 1'b0;
			rsp_due      = 1'b0;
			prev_rsp     = '0;
			check_count  = 0;
			test_base    = 0;
			error_count  = 0;
		end else begin
			// Masked clear lands one edge after the ack, flags of that edge survive
			if (clear_due) begin
				acc_cmd   = acc_cmd & ~snap[WORD_W-1 -: CMD_W];
				acc_rsp   = acc_rsp & ~snap[DATA_W +: RSP_W];
				acc_data  = acc_data & ~snap[DATA_W-1:0];
				clear_due = 1'b0;
			end

			// Response registered one cycle after the request
			if (rsp_due && !host_rsp_valid) begin
				report_error("no response one cycle after the request");
			end
			rsp_due = 1'b0;

			// Held response must not move
			if (prev_stalled && (!host_rsp_valid || host_rsp !== prev_rsp)) begin
				report_error("response changed while stalled");
			end
			if (host_rsp_valid && host_req_ready) begin
				report_error("request ready while a response is held");
			end

			if (host_rsp_valid && host_rsp_ready) begin
				expected = expected_response(exp_tag, exp_pending, snap);
				check_count++;
				if (host_rsp !== expected) begin
					report_error($sformatf(
						"got tag %h data %h pend %b, want tag %h data %h pend %b",
						host_rsp.tag, host_rsp.data, host_rsp.pending,
						expected.tag, expected.data, expected.pending));
				end
				// Reported bits get cleared, later ones stay
				clear_due = expected.pending;
			end

			// Unreported flags held means a report is pending
			if (host_req_valid && host_req_ready) begin
				exp_tag     = host_req.tag;
				exp_pending = |pack_word(acc_cmd, acc_rsp, acc_data);
				rsp_due     = 1'b1;
			end

			// Snapshot froze one edge before the interrupt, on captures one edge older
			if (error_interrupt && !int_prev) begin
				snap = acc_d2;
			end

			// Accumulate and shift history
			acc_d2   = acc_d1;
			acc_d1   = acc_now;
			acc_cmd  = acc_cmd | cmd_errors;
			acc_rsp  = acc_rsp | rsp_errors;
			acc_data = acc_data | data_errors;
			acc_now  = pack_word(acc_cmd, acc_rsp, acc_data);

			int_prev     = error_interrupt;
			prev_stalled = host_rsp_valid && !host_rsp_ready;
			prev_rsp     = host_rsp;

			if (test_end) begin
				$display("test %0d %s done, %0d errors", test_num, test_name(test_num),
					error_count + stim_errors - test_base);
				test_base = error_count + stim_errors;
			end
			if (run_done) begin
				$display("responses checked %0d, errors %0d", check_count,
					error_count + stim_errors);
			end
		end
	end

endmodule

/* rtl/error_subsystem.sv */
`timescale 1ns/1ps

module error_subsystem (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  error_pkg::cmd_error_t  cmd_errors,
	input  error_pkg::rsp_error_t  rsp_errors,
	input  error_pkg::data_error_t data_errors,
	input  logic                   host_req_valid,
	output logic                   host_req_ready,
	input  error_pkg::host_req_t   host_req,
	output logic                   host_rsp_valid,
	input  logic                   host_rsp_ready,
	output error_pkg::host_rsp_t   host_rsp,
	output logic                   error_interrupt
);

	import error_pkg::*;

	// Sticky flags per source
	cmd_error_t  cmd_captured;
	rsp_error_t  rsp_captured;
	data_error_t data_captured;

	// Packed word into control, snapshot back out
	error_word_t external_errors;
	error_word_t report_errors;

	logic report_pending;
	logic report_ack;
	logic clear_errors;

	// --------------------
	// Capture
	// --------------------

	// Each clear mask is the matching field of the snapshot
	error_capture #(.payload_t(cmd_error_t)) i_cmd_capture (
		.clock      (clock),
		.rstn       (rstn),
		.error_in   (cmd_errors),
		.clear      (clear_errors),
		.clear_mask (report_errors.cmd),
		.captured   (cmd_captured)
	);

	error_capture #(.payload_t(rsp_error_t)) i_rsp_capture (
		.clock      (clock),
		.rstn       (rstn),
		.error_in   (rsp_errors),
		.clear      (clear_errors),
		.clear_mask (report_errors.rsp),
		.captured   (rsp_captured)
	);

	error_capture #(.payload_t(data_error_t)) i_data_capture (
		.clock      (clock),
		.rstn       (rstn),
		.error_in   (data_errors),
		.clear      (clear_errors),
		.clear_mask (report_errors.data),
		.captured   (data_captured)
	);

	// Command on top, data at the bottom
	assign external_errors = '{cmd: cmd_captured, rsp: rsp_captured, data: data_captured};

	// --------------------
	// Control and host port
	// --------------------

	error_control i_error_control (
		.clock           (clock),
		.rstn            (rstn),
		.enabled         (enabled),
		.external_errors (external_errors),
		.report_ack      (report_ack),
		.report_errors   (report_errors),
		.report_pending  (report_pending),
		.clear_errors    (clear_errors)
	);

	error_report_mmio i_error_report_mmio (
		.clock           (clock),
		.rstn            (rstn),
		.host_req_valid  (host_req_valid),
		.host_req_ready  (host_req_ready),
		.host_req        (host_req),
		.host_rsp_valid  (host_rsp_valid),
		.host_rsp_ready  (host_rsp_ready),
		.host_rsp        (host_rsp),
		.report_errors   (report_errors),
		.report_pending  (report_pending),
		.report_ack      (report_ack),
		.error_interrupt (error_interrupt)
	);

endmodule

/* rtl/error_report_mmio.sv */
`timescale 1ns/1ps

module error_report_mmio (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   host_req_valid,
	output logic                   host_req_ready,
	input  error_pkg::host_req_t   host_req,
	output logic                   host_rsp_valid,
	input  logic                   host_rsp_ready,
	output error_pkg::host_rsp_t   host_rsp,
	input  error_pkg::error_word_t report_errors,
	input  logic                   report_pending,
	output logic                   report_ack,
	output logic                   error_interrupt
);

	import error_pkg::*;

	// Handshake events
	logic req_accept;
	logic rsp_accept;

	// Response built from the accepted request
	host_rsp_t rsp_next;

	// --------------------
	// Handshakes
	// --------------------

	// One response register, no new request while it is held
	assign host_req_ready = !host_rsp_valid;
	assign req_accept     = host_req_valid && host_req_ready;
	assign rsp_accept     = host_rsp_valid && host_rsp_ready;

	// Snapshot only when a report is pending, zero otherwise
	always_comb begin
		rsp_next.tag = host_req.tag;
		if (report_pending) begin
			rsp_next.data    = report_errors;
			rsp_next.pending = 1'b1;
		end else begin
			rsp_next.data    = '0;
			rsp_next.pending = 1'b0;
		end
	end

	// --------------------
	// Response register
	// --------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			host_rsp_valid <= 1'b0;
		end else if (req_accept) begin
			host_rsp_valid <= 1'b1;
		end else if (rsp_accept) begin
			host_rsp_valid <= 1'b0;
		end
	end

	// Loaded on accept only, stable while stalled
	always_ff @(posedge clock) begin
		if (req_accept) begin
			host_rsp <= rsp_next;
		end
	end

	// --------------------
	// Control side
	// --------------------

	// Ack on handover of a pending report only
	assign report_ack = rsp_accept && host_rsp.pending;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			error_interrupt <= 1'b0;
		end else begin
			error_interrupt <= report_pending;
		end
	end

endmodule

/* rtl/error_control.sv */
`timescale 1ns/1ps

`include "error_consts.svh"

module error_control (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  error_pkg::error_word_t external_errors,
	input  logic                   report_ack,
	output error_pkg::error_word_t report_errors,
	output logic                   report_pending,
	output logic                   clear_errors
);

	import error_pkg::*;

	// Release synchronizer chain
	logic [`ERR_RSTN_SYNC_STAGES-1:0] rstn_sync;
	logic                             rstn_int;

	// Registered enable
	logic enabled_q;

	// FSM
	error_state_t state;
	error_state_t next_state;

	// Any bit set in the incoming word
	logic error_flag;

	// Ack seen while the FSM was held
	logic ack_held;
	logic ack_seen;

	// --------------------
	// Reset synchronizer
	// --------------------

	// Assert immediately, release after the chain fills
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rstn_sync <= '0;
		end else begin
			rstn_sync <= {rstn_sync[`ERR_RSTN_SYNC_STAGES-2:0], 1'b1};
		end
	end

	assign rstn_int = rstn_sync[`ERR_RSTN_SYNC_STAGES-1];

	// --------------------
	// Enable register
	// --------------------

	always_ff @(posedge clock or negedge rstn_int) begin
		if (!rstn_int) begin
			enabled_q <= 1'b0;
		end else begin
			enabled_q <= enabled;
		end
	end

	// --------------------
	// Ack latch
	// --------------------

	// Keep an ack that lands while disabled
	always_ff @(posedge clock or negedge rstn_int) begin
		if (!rstn_int) begin
			ack_held <= 1'b0;
		end else if (state != ERROR_MMIO_REQ || enabled_q) begin
			ack_held <= 1'b0;
		end else if (report_ack) begin
			ack_held <= 1'b1;
		end
	end

	assign ack_seen   = report_ack | ack_held;
	assign error_flag = |external_errors;

	// --------------------
	// Report FSM
	// --------------------

	// Advances only while enabled
	always_ff @(posedge clock or negedge rstn_int) begin
		if (!rstn_int) begin
			state <= ERROR_RESET;
		end else if (enabled_q) begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			ERROR_RESET: begin
				next_state = ERROR_IDLE;
			end
			// Leave on the first nonzero word
			ERROR_IDLE: begin
				if (error_flag) begin
					next_state = ERROR_MMIO_REQ;
				end
			end
			// Wait for the host read
			ERROR_MMIO_REQ: begin
				if (ack_seen) begin
					next_state = ERROR_CLEAR_REQ;
				end
			end
			ERROR_CLEAR_REQ: begin
				next_state = ERROR_CLEAR_PENDING;
			end
			ERROR_CLEAR_PENDING: begin
				next_state = ERROR_IDLE;
			end
			default: begin
				next_state = ERROR_RESET;
			end
		endcase
	end

	// --------------------
	// Snapshot register
	// --------------------

	// Tracks the word in idle, frozen otherwise
	always_ff @(posedge clock) begin
		if (enabled_q) begin
			case (state)
				ERROR_RESET: report_errors <= '0;
				ERROR_IDLE:  report_errors <= external_errors;
				default:     report_errors <= report_errors;
			endcase
		end
	end

	assign report_pending = (state == ERROR_MMIO_REQ);

	// Single strobe, masked by the snapshot at the captures
	assign clear_errors = enabled_q && (state == ERROR_CLEAR_REQ);

endmodule

/* rtl/error_capture.sv */
`timescale 1ns/1ps

module error_capture #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clock,
	input  logic     rstn,
	input  payload_t error_in,
	input  logic     clear,
	input  payload_t clear_mask,
	output payload_t captured
);

	// --------------------
	// Clear selection
	// --------------------

	// Bits removed this cycle, only on the strobe
	payload_t clear_bits;

	// Held bits minus the cleared ones, new flags on top
	payload_t next_captured;

	always_comb begin
		if (clear) begin
			clear_bits = clear_mask;
		end else begin
			clear_bits = payload_t'('0);
		end
	end

	// Same-cycle flags survive the clear
	always_comb begin
		next_captured = payload_t'((captured & ~clear_bits) | error_in);
	end

	// --------------------
	// Sticky register
	// --------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			captured <= payload_t'('0);
		end else begin
			captured <= next_captured;
		end
	end

	// Flags stay until the control
	// strobe names them in the mask

endmodule

/* rtl/error_pkg.sv */
`include "error_consts.svh"

package error_pkg;

	// --------------------
	// Per-source error flags
	// --------------------

	// Command engine, eight named flags over a reserved tail
	typedef struct packed {
		logic [`ERR_CMD_WIDTH-9:0] reserved;
		logic                      tag_overflow;
		logic                      credit_underflow;
		logic                      cmd_fifo_overflow;
		logic                      cmd_fifo_underflow;
		logic                      bad_opcode;
		logic                      bad_address;
		logic                      page_fault;
		logic                      buffer_overrun;
	} cmd_error_t;

	// Response engine
	typedef struct packed {
		logic [`ERR_RSP_WIDTH-9:0] reserved;
		logic                      rsp_fifo_overflow;
		logic                      unexpected_tag;
		logic                      aerror;
		logic                      derror;
		logic                      nlock;
		logic                      nres;
		logic                      fault;
		logic                      failed;
	} rsp_error_t;

	// Data path
	typedef struct packed {
		logic [`ERR_DATA_WIDTH-9:0] reserved;
		logic                       read_parity;
		logic                       write_parity;
		logic                       read_fifo_overflow;
		logic                       write_fifo_overflow;
		logic                       buffer_overrun;
		logic                       misaligned;
		logic                       ecc_single;
		logic                       ecc_double;
	} data_error_t;

	// --------------------
	// Report word and host port
	// --------------------

	// 64 bits, command field at the top, data field at the bottom
	typedef struct packed {
		cmd_error_t  cmd;
		rsp_error_t  rsp;
		data_error_t data;
	} error_word_t;

	typedef struct packed {
		logic [3:0] tag;
	} host_req_t;

	// Echoed tag, word, and whether a report was pending
	typedef struct packed {
		logic [3:0]  tag;
		error_word_t data;
		logic        pending;
	} host_rsp_t;

	// Report FSM states
	typedef enum logic [2:0] {
		ERROR_RESET,
		ERROR_IDLE,
		ERROR_MMIO_REQ,
		ERROR_CLEAR_REQ,
		ERROR_CLEAR_PENDING
	} error_state_t;

endpackage

/* rtl/error_consts.svh */
`ifndef ERROR_CONSTS_SVH
`define ERROR_CONSTS_SVH

// --------------------
// Error source field widths
// --------------------

// Command engine flags, top field of the report word
`define ERR_CMD_WIDTH 16

// Response engine flags, middle field
`define ERR_RSP_WIDTH 16

// Data path flags, bottom field
`define ERR_DATA_WIDTH 32

// --------------------
// Reset release
// --------------------

// Flops in the rstn release synchronizer, at least two
`define ERR_RSTN_SYNC_STAGES 2

`endif
